// ==== tb.f ====
design/csPkg.sv
design/busPkg.sv
design/csAccessDecode.sv
design/csTransceiver.sv
design/controlStore.sv
design/microInstrReg.sv
design/csTop.sv
tests/csTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the control store testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module csTb -Mdir obj_dir -o csTb -f tb.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/csTb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0

// ==== tests/csTb.sv ====
// Control store testbench
`timescale 1ns/1ps

module csTb;

  localparam int AW = 8;
  localparam int DEPTH = 1 << AW;
  // planned stimulus length in clock cycles
  // the watchdog allows four times as much
  localparam int STIM_CYCLES = 500;

  // DUT outputs expected at one falling edge
  typedef struct packed {
    logic           idbValid;
    busPkg::idbWord idbOut;
    logic           bitsValid;
    csPkg::csWord   bits;
  } expectT;

  logic                     clk;
  logic                     rst;
  busPkg::idbWord           idbIn;
  busPkg::idbWord           idbOut;
  logic                     idbValid;
  logic [AW-1:0]            csAddr;
  logic                     wcsN;
  logic                     ecslN;
  logic [csPkg::SLICES-1:0] ewN;
  logic                     fetch;
  logic [AW-1:0]            fetchAddr;
  csPkg::csWord             csBits;
  logic                     csBitsValid;

  // reference copy of the control store contents
  csPkg::csWord model [DEPTH];
  // word that csBits should show once the latest fetch has arrived
  csPkg::csWord lastFetch;
  // one entry per cycle that is checked three falling edges after it was pushed
  expectT       expQ[$];
  int           seed = 32'h06ece2e4;

  csTop #(.ADDR_WIDTH(AW)) DUT (
    .clk(clk), .rst(rst), .idbIn(idbIn), .idbOut(idbOut), .idbValid(idbValid),
    .csAddr(csAddr), .wcsN(wcsN), .ecslN(ecslN), .ewN(ewN),
    .fetch(fetch), .fetchAddr(fetchAddr), .csBits(csBits), .csBitsValid(csBitsValid)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // end the run if the stimulus stalls
  initial begin
    repeat (4 * STIM_CYCLES) @(posedge clk);
    $display("Timeout: the test did not finish within %0d cycles", 4 * STIM_CYCLES);
    $display("TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

  task automatic reportMismatch(input string name, input logic [63:0] expVal,
                                input logic [63:0] actVal);
    $display("** Error at %0t: %s expected %h, got %h", $time, name, expVal, actVal);
    $display("TESTS FAILED");
    $fatal(1, "stopped at the first mismatch");
  endtask

  function automatic logic [31:0] nextRandom();
    return $random(seed);
  endfunction

  // the bus shows the highest enabled slice of the word
  function automatic busPkg::idbWord highestSlice(input csPkg::csWord w,
                                                  input csPkg::sliceMask m);
    for (int s = csPkg::SLICES - 1; s >= 0; s--) begin
      if (m[s]) begin
        return w[s*csPkg::SLICE_WIDTH +: csPkg::SLICE_WIDTH];
      end
    end
    return '0;
  endfunction

  // all DUT outputs are registered and so are stable at the falling edge
  task automatic checkOutputs();
    expectT e;
    e = expQ.pop_front();
    assert (idbValid === e.idbValid)
      else reportMismatch("idbValid", 64'(e.idbValid), 64'(idbValid));
    assert (idbOut === e.idbOut)
      else reportMismatch("idbOut", 64'(e.idbOut), 64'(idbOut));
    assert (csBitsValid === e.bitsValid)
      else reportMismatch("csBitsValid", 64'(e.bitsValid), 64'(csBitsValid));
    assert (csBits === e.bits)
      else reportMismatch("csBits", e.bits, csBits);
  endtask

  // each cycle checks the outputs due now and then drives the next inputs
  task automatic runCycle(input logic wN, input logic eN, input logic [3:0] enN,
                          input logic [AW-1:0] addr, input busPkg::idbWord data,
                          input logic fe, input logic [AW-1:0] fAddr);
    csPkg::sliceMask m;
    logic            isWrite;
    logic            isRead;
    expectT          e;
    @(negedge clk);
    checkOutputs();
    wcsN      = wN;
    ecslN     = eN;
    ewN       = enN;
    csAddr    = addr;
    idbIn     = data;
    fetch     = fe;
    fetchAddr = fAddr;
    m       = ~enN;
    // a low write strobe means write and otherwise the enable strobe asks for a read
    isWrite = !wN && |m;
    isRead  = wN && !eN && |m;
    e.idbValid = isRead;
    e.idbOut   = isRead ? highestSlice(model[addr], m) : '0;
    // a fetch sees the store as it was before this cycle's write
    if (fe) begin
      lastFetch = model[fAddr];
    end
    e.bitsValid = fe;
    e.bits      = lastFetch;
    if (isWrite) begin
      for (int s = 0; s < csPkg::SLICES; s++) begin
        if (m[s]) begin
          model[addr][s*csPkg::SLICE_WIDTH +: csPkg::SLICE_WIDTH] = data;
        end
      end
    end
    expQ.push_back(e);
  endtask

  task automatic writeSlices(input logic [AW-1:0] addr, input csPkg::sliceMask m,
                             input busPkg::idbWord data);
    runCycle(1'b0, 1'b1, ~m, addr, data, 1'b0, '0);
  endtask

  task automatic readSlices(input logic [AW-1:0] addr, input csPkg::sliceMask m);
    runCycle(1'b1, 1'b0, ~m, addr, '0, 1'b0, '0);
  endtask

  task automatic fetchWord(input logic [AW-1:0] addr);
    runCycle(1'b1, 1'b1, 4'hF, '0, '0, 1'b1, addr);
  endtask

  task automatic idleCycles(input int n);
    repeat (n) runCycle(1'b1, 1'b1, 4'hF, '0, '0, 1'b0, '0);
  endtask

  initial begin
    logic [31:0]     r;
    logic [AW-1:0]   a;
    csPkg::sliceMask m;
    rst       = 1'b1;
    wcsN      = 1'b1;
    ecslN     = 1'b1;
    ewN       = 4'hF;
    idbIn     = '0;
    csAddr    = '0;
    fetch     = 1'b0;
    fetchAddr = '0;
    lastFetch = '0;
    // the first three checks cover the state right after reset
    repeat (3) expQ.push_back('0);
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // every microword gets a known value built from its address
    for (int i = 0; i < DEPTH; i++) begin
      a = i[AW-1:0];
      writeSlices(a, 4'hF, {~a, a});
    end

    // single slice writes are read back at once and then a neighbor slice is read
    repeat (24) begin
      r = nextRandom();
      a = r[AW-1:0];
      m = 4'b0001 << r[9:8];
      writeSlices(a, m, r[31:16]);
      readSlices(a, m);
      idleCycles(int'(r[10]));
      readSlices(a, 4'b0001 << (r[9:8] + 2'd1));
    end

    // multi slice writes leave the disabled slices alone
    repeat (12) begin
      r = nextRandom();
      a = r[AW-1:0];
      m = r[11:8];
      if ($countones(m) < 2) begin
        m = ~m;
      end
      writeSlices(a, m, r[31:16]);
      for (int k = 0; k < csPkg::SLICES; k++) begin
        readSlices(a, 4'b0001 << k);
      end
      r = nextRandom();
      readSlices(a, (r[3:0] == 4'h0) ? 4'hF : r[3:0]);
    end

    // csBits has to hold in the gaps between spaced fetches
    repeat (10) begin
      r = nextRandom();
      fetchWord(r[AW-1:0]);
      idleCycles(1 + int'(r[9:8]));
    end
    // back to back fetches come out one per cycle
    repeat (8) begin
      r = nextRandom();
      fetchWord(r[AW-1:0]);
    end
    idleCycles(2);

    // write and fetch one address together and then read and fetch it again
    // slice 3 is always written and slice 0 never, so the new word has distinct slices
    repeat (6) begin
      r = nextRandom();
      a = r[AW-1:0];
      runCycle(1'b0, 1'b1, {1'b0, r[10:9], 1'b1}, a, r[31:16], 1'b1, a);
      readSlices(a, 4'hF);
      fetchWord(a);
    end

    repeat (2) begin
      r = nextRandom();
      a = r[AW-1:0];
      // both strobes low is still a write and nothing appears on the bus
      runCycle(1'b0, 1'b0, 4'b1100, a, r[31:16], 1'b0, '0);
      readSlices(a, 4'b0001);
      readSlices(a, 4'b0100);
      // with no slice enabled neither a write nor a read happens
      runCycle(1'b0, 1'b1, 4'hF, a, ~r[31:16], 1'b0, '0);
      runCycle(1'b1, 1'b0, 4'hF, a, '0, 1'b0, '0);
      readSlices(a, 4'b0010);
      readSlices(a, 4'b1000);
    end

    // let the last requests come out of the pipeline
    idleCycles(3);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== design/csTop.sv ====
// Writable control store top level
`timescale 1ns/1ps

module csTop #(
  parameter int ADDR_WIDTH = csPkg::ADDR_WIDTH_DEFAULT
) (
  input  logic                     clk,
  input  logic                     rst,
  input  busPkg::idbWord           idbIn,
  output busPkg::idbWord           idbOut,
  output logic                     idbValid,
  input  logic [ADDR_WIDTH-1:0]    csAddr,
  input  logic                     wcsN,
  input  logic                     ecslN,
  input  logic [csPkg::SLICES-1:0] ewN,
  input  logic                     fetch,
  input  logic [ADDR_WIDTH-1:0]    fetchAddr,
  output csPkg::csWord             csBits,
  output logic                     csBitsValid
);

  busPkg::csAccess       hostReq;
  logic [ADDR_WIDTH-1:0] memAddr;
  csPkg::sliceMask       memWrMask;
  csPkg::csWord          memWrData;
  csPkg::csWord          memRdData;
  csPkg::csWord          fetchRdData;

  // fetch request stage, mirrors the host decoder so both ports reach memory together
  logic                  fetchReq;
  logic [ADDR_WIDTH-1:0] fetchAddrQ;
  // fetch flag delayed to line up with the registered fetch data
  logic                  fetchPending;

  always_ff @(posedge clk) begin
    fetchAddrQ <= fetchAddr;
    if (rst) begin
      fetchReq     <= 1'b0;
      fetchPending <= 1'b0;
    end else begin
      fetchReq     <= fetch;
      fetchPending <= fetchReq;
    end
  end

  // input side, strobes to one registered request
  csAccessDecode #(.ADDR_WIDTH(ADDR_WIDTH)) uDecode (
    .clk(clk), .rst(rst), .idbIn(idbIn), .csAddr(csAddr),
    .wcsN(wcsN), .ecslN(ecslN), .ewN(ewN), .hostReq(hostReq)
  );

  // slice steering between the IDB and the microword
  csTransceiver #(.ADDR_WIDTH(ADDR_WIDTH)) uTcv (
    .clk(clk), .rst(rst), .hostReq(hostReq),
    .memAddr(memAddr), .memWrMask(memWrMask), .memWrData(memWrData),
    .memRdData(memRdData), .idbOut(idbOut), .idbValid(idbValid)
  );

  controlStore #(.ADDR_WIDTH(ADDR_WIDTH)) uStore (
    .clk(clk), .hostAddr(memAddr), .hostWrMask(memWrMask),
    .hostWrData(memWrData), .hostRdData(memRdData),
    .fetchAddr(fetchAddrQ), .fetchRdData(fetchRdData)
  );

  // output side, drives the CPU control bits
  microInstrReg uMir (
    .clk(clk), .rst(rst), .fetchPending(fetchPending),
    .fetchRdData(fetchRdData), .csBits(csBits), .csBitsValid(csBitsValid)
  );

endmodule

// ==== design/microInstrReg.sv ====
// Microinstruction register
`timescale 1ns/1ps

module microInstrReg (
  input  logic         clk,
  input  logic         rst,
  input  logic         fetchPending,
  input  csPkg::csWord fetchRdData,
  output csPkg::csWord csBits,
  output logic         csBitsValid
);

  // the control bits stay put between fetches so the CPU sees a stable word
  // an all-zero microword is a no-op, which is the safe value after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      csBits      <= '0;
      csBitsValid <= 1'b0;
    end else begin
      // valid is high only in the cycle after a new word was taken
      csBitsValid <= fetchPending;
      if (fetchPending) begin
        csBits <= fetchRdData;
      end
    end
  end

endmodule

// ==== design/controlStore.sv ====
// Dual-port control store
`timescale 1ns/1ps

module controlStore #(
  parameter int ADDR_WIDTH = csPkg::ADDR_WIDTH_DEFAULT
) (
  input  logic                  clk,
  input  logic [ADDR_WIDTH-1:0] hostAddr,
  input  csPkg::sliceMask       hostWrMask,
  input  csPkg::csWord          hostWrData,
  output csPkg::csWord          hostRdData,
  input  logic [ADDR_WIDTH-1:0] fetchAddr,
  output csPkg::csWord          fetchRdData
);

  localparam int DEPTH = 1 << ADDR_WIDTH;

  // microword array, contents are undefined until the host loads them
  csPkg::csWord mem [DEPTH];

  // host port
  // each slice has its own write enable so a partial update keeps the other slices
  always_ff @(posedge clk) begin
    for (int i = 0; i < csPkg::SLICES; i++) begin
      if (hostWrMask[i]) begin
        mem[hostAddr][i*csPkg::SLICE_WIDTH +: csPkg::SLICE_WIDTH] <=
          hostWrData[i*csPkg::SLICE_WIDTH +: csPkg::SLICE_WIDTH];
      end
    end
    // registered read, a read and write to one address in the same cycle returns old data
    hostRdData <= mem[hostAddr];
  end

  // fetch port, read only
  // it runs every cycle and does not wait for the host port
  always_ff @(posedge clk) begin
    // a host write landing on this edge is not seen here
    fetchRdData <= mem[fetchAddr];
  end

endmodule

// ==== design/csTransceiver.sv ====
// Control store slice transceiver
`timescale 1ns/1ps

module csTransceiver #(
  parameter int ADDR_WIDTH = csPkg::ADDR_WIDTH_DEFAULT
) (
  input  logic                  clk,
  input  logic                  rst,
  input  busPkg::csAccess       hostReq,
  output logic [ADDR_WIDTH-1:0] memAddr,
  output csPkg::sliceMask       memWrMask,
  output csPkg::csWord          memWrData,
  input  csPkg::csWord          memRdData,
  output busPkg::idbWord        idbOut,
  output logic                  idbValid
);

  // read request delayed to line up with the registered memory data
  logic            rdPending;
  csPkg::sliceMask rdMask;
  csPkg::csSlice   readSlice;

  // only the low address bits reach the memory
  assign memAddr = hostReq.addr[ADDR_WIDTH-1:0];

  // the IDB word is copied to every slice position
  // and the mask picks which of them are actually stored
  assign memWrData = {csPkg::SLICES{hostReq.data}};
  assign memWrMask = hostReq.isWrite ? hostReq.mask : '0;

  // the memory answers one cycle after the request
  always_ff @(posedge clk) begin
    rdMask <= hostReq.mask;
    if (rst) begin
      rdPending <= 1'b0;
    end else begin
      rdPending <= hostReq.isRead;
    end
  end

  // pick one slice of the returned word
  // later slices overwrite earlier ones so the highest enabled slice wins
  always_comb begin
    readSlice = '0;
    for (int i = 0; i < csPkg::SLICES; i++) begin
      if (rdMask[i]) begin
        readSlice = memRdData[i*csPkg::SLICE_WIDTH +: csPkg::SLICE_WIDTH];
      end
    end
  end

  // the bus is driven only in the valid cycle and is zero otherwise
  always_ff @(posedge clk) begin
    if (rst) begin
      idbValid <= 1'b0;
      idbOut   <= '0;
    end else begin
      idbValid <= rdPending;
      idbOut   <= rdPending ? readSlice : '0;
    end
  end

endmodule

// ==== design/csAccessDecode.sv ====
// IDB access decoder
`timescale 1ns/1ps

module csAccessDecode #(
  parameter int ADDR_WIDTH = csPkg::ADDR_WIDTH_DEFAULT
) (
  input  logic                    clk,
  input  logic                    rst,
  input  busPkg::idbWord          idbIn,
  input  logic [ADDR_WIDTH-1:0]   csAddr,
  input  logic                    wcsN,
  input  logic                    ecslN,
  input  logic [csPkg::SLICES-1:0] ewN,
  output busPkg::csAccess         hostReq
);

  // the slice enables arrive active low, the rest of the design works with a mask
  csPkg::sliceMask mask;
  logic            anySlice;
  busPkg::csAccess nextReq;

  assign mask     = ~ewN;
  assign anySlice = |mask;

  // classify the cycle from the strobes
  always_comb begin
    nextReq = '0;
    // a low write strobe means IDB to control store, the enable strobe is not needed
    nextReq.isWrite = !wcsN && anySlice;
    // with the write strobe high the direction is control store to IDB
    // and the enable strobe decides whether the data goes out at all
    nextReq.isRead = wcsN && !ecslN && anySlice;
    nextReq.mask   = mask;
    nextReq.data   = idbIn;
    // zero-extend the address into the full request field
    nextReq.addr[ADDR_WIDTH-1:0] = csAddr;
  end

  // one request per cycle, later stages never see the raw strobes
  always_ff @(posedge clk) begin
    hostReq.mask <= nextReq.mask;
    hostReq.data <= nextReq.data;
    hostReq.addr <= nextReq.addr;
    if (rst) begin
      hostReq.isWrite <= 1'b0;
      hostReq.isRead  <= 1'b0;
    end else begin
      hostReq.isWrite <= nextReq.isWrite;
      hostReq.isRead  <= nextReq.isRead;
    end
  end

endmodule

// ==== design/busPkg.sv ====
// IDB access types
package busPkg;

  // the internal data bus is one slice wide
  localparam int IDB_WIDTH = 16;

  // address field in a request is sized for the largest store
  // a smaller store uses only the low bits
  localparam int ACCESS_ADDR_WIDTH = 16;

  // one word on the IDB
  typedef logic [IDB_WIDTH-1:0] idbWord;

  // one host access as registered by the decoder
  // isWrite and isRead are never both set
  typedef struct packed {
    logic isWrite;
    logic isRead;
    csPkg::sliceMask mask;
    idbWord data;
    logic [ACCESS_ADDR_WIDTH-1:0] addr;
  } csAccess;

endpackage

// ==== design/csPkg.sv ====
// Control store types
package csPkg;

  // one slice is the part of a microword that fits on the IDB at once
  localparam int SLICE_WIDTH = 16;

  // a microword is built from four slices, slice 0 holds bits 15:0
  localparam int SLICES = 4;

  // default depth is 256 microwords
  localparam int ADDR_WIDTH_DEFAULT = 8;

  // one 16-bit piece of a microword
  typedef logic [SLICE_WIDTH-1:0] csSlice;

  // a whole microword, the control bits of one CPU step
  typedef logic [SLICES*SLICE_WIDTH-1:0] csWord;

  // one bit per slice, 1 selects the slice
  // this is the inverted form of the active-low slice enables on the bus
  typedef logic [SLICES-1:0] sliceMask;

endpackage
